//--- verilog/spi_pkg.sv
package spi_pkg;

  // One SPI byte, also the host data width
  typedef logic [7:0] spi_byte_t;

  // Peripheral register address
  typedef logic [6:0] reg_addr_t;

  // sclk phase counter width, one sclk period is 2**SCLK_CNT_W clk cycles
  localparam int SCLK_CNT_W = 2;

  // Valid peripheral registers are 0 .. REG_COUNT-1
  localparam int REG_COUNT = 16;

  // Chip select guard time around the sclk activity, in clk cycles
  localparam int CS_GUARD = 2;
  localparam int GUARD_CNT_W = $clog2(CS_GUARD + 1);

  typedef enum logic [1:0] {
    BYTE_IDLE,
    BYTE_SHIFT,
    BYTE_TAIL
  } byte_state_e;

  typedef enum logic [2:0] {
    FRAME_IDLE,
    FRAME_SETUP,
    FRAME_BYTE0,
    FRAME_BYTE1,
    FRAME_HOLD
  } frame_state_e;

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_BUSY,
    HS_ACK,
    HS_RELEASE
  } hs_state_e;

endpackage

//--- verilog/spi_cmd_decode.sv
`timescale 1ns/1ps

module spi_cmd_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               accept,
  input  logic               write,
  input  spi_pkg::reg_addr_t addr,
  input  spi_pkg::spi_byte_t wdata,
  output logic               frame_start,
  output spi_pkg::spi_byte_t byte0,
  output spi_pkg::spi_byte_t byte1,
  output logic               reject,
  output logic               write_cmd
);

  logic addr_ok;

  // Only registers below REG_COUNT exist in the peripheral
  assign addr_ok = addr < spi_pkg::reg_addr_t'(spi_pkg::REG_COUNT);

  // Request pulses and the latched operation
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_start <= 1'b0;
      reject      <= 1'b0;
      write_cmd   <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      reject      <= 1'b0;
      if (accept) begin
        write_cmd <= write;
        if (addr_ok) begin
          frame_start <= 1'b1;
        end else begin
          reject <= 1'b1;
        end
      end
    end
  end

  // Frame bytes, stable until the next accepted command
  always_ff @(posedge clk) begin
    if (accept) begin
      byte0 <= {write, addr};
      if (write) begin
        byte1 <= wdata;
      end else begin
        // Read sends a dummy byte while the register comes back
        byte1 <= '0;
      end
    end
  end

endmodule

//--- verilog/spi_byte_engine.sv
`timescale 1ns/1ps

module spi_byte_engine (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  spi_pkg::spi_byte_t tx_byte,
  input  logic               miso,
  output logic               sclk,
  output logic               mosi,
  output logic               done,
  output spi_pkg::spi_byte_t rx_data
);

  spi_pkg::byte_state_e state_q, state_d;
  logic [spi_pkg::SCLK_CNT_W-1:0] sclk_cnt_q, sclk_cnt_d;
  logic [2:0] bit_cnt_q, bit_cnt_d;
  logic mosi_q, mosi_d;
  logic done_q, done_d;
  spi_pkg::spi_byte_t shift_q, shift_d;
  spi_pkg::spi_byte_t rx_q, rx_d;
  logic half_period;

  // Mode 0, sclk high during the upper half of the phase count
  assign sclk = sclk_cnt_q[spi_pkg::SCLK_CNT_W-1] & (state_q == spi_pkg::BYTE_SHIFT);
  assign mosi = mosi_q;
  assign done = done_q;
  assign rx_data = rx_q;

  // Last count of the low half
  assign half_period = !sclk_cnt_q[spi_pkg::SCLK_CNT_W-1] &&
                       (&sclk_cnt_q[spi_pkg::SCLK_CNT_W-2:0]);

  always_comb begin
    state_d    = state_q;
    sclk_cnt_d = sclk_cnt_q;
    bit_cnt_d  = bit_cnt_q;
    mosi_d     = mosi_q;
    done_d     = 1'b0;
    shift_d    = shift_q;
    rx_d       = rx_q;

    case (state_q)
      spi_pkg::BYTE_IDLE: begin
        sclk_cnt_d = '0;
        bit_cnt_d  = '0;
        mosi_d     = 1'b0;
        if (start) begin
          shift_d = tx_byte;
          state_d = spi_pkg::BYTE_SHIFT;
        end
      end

      spi_pkg::BYTE_SHIFT: begin
        sclk_cnt_d = sclk_cnt_q + 1'b1;
        // Drive the next bit at the start of the low half
        if (sclk_cnt_q == '0) begin
          mosi_d = shift_q[7];
        end
        // Sample just before sclk falls
        if (&sclk_cnt_q) begin
          shift_d   = {shift_q[6:0], miso};
          bit_cnt_d = bit_cnt_q + 1'b1;
          if (&bit_cnt_q) begin
            rx_d    = {shift_q[6:0], miso};
            state_d = spi_pkg::BYTE_TAIL;
          end
        end
      end

      spi_pkg::BYTE_TAIL: begin
        sclk_cnt_d = sclk_cnt_q + 1'b1;
        if (half_period) begin
          sclk_cnt_d = '0;
          done_d     = 1'b1;
          state_d    = spi_pkg::BYTE_IDLE;
        end
      end

      default: state_d = spi_pkg::BYTE_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= spi_pkg::BYTE_IDLE;
      sclk_cnt_q <= '0;
      bit_cnt_q  <= '0;
      mosi_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q    <= state_d;
      sclk_cnt_q <= sclk_cnt_d;
      bit_cnt_q  <= bit_cnt_d;
      mosi_q     <= mosi_d;
      done_q     <= done_d;
    end
  end

  always_ff @(posedge clk) begin
    shift_q <= shift_d;
    rx_q    <= rx_d;
  end

endmodule

//--- verilog/spi_frame_exec.sv
`timescale 1ns/1ps

module spi_frame_exec (
  input  logic               clk,
  input  logic               rst,
  input  logic               frame_start,
  input  spi_pkg::spi_byte_t byte0,
  input  spi_pkg::spi_byte_t byte1,
  input  logic               miso,
  output logic               cs_n,
  output logic               sclk,
  output logic               mosi,
  output logic               frame_done,
  output spi_pkg::spi_byte_t rx_byte
);

  spi_pkg::frame_state_e state;
  logic [spi_pkg::GUARD_CNT_W-1:0] guard_cnt;
  logic guard_end;
  logic byte_start;
  logic byte_done;
  spi_pkg::spi_byte_t tx_byte;
  spi_pkg::spi_byte_t rx_data;

  assign guard_end = guard_cnt == spi_pkg::GUARD_CNT_W'(spi_pkg::CS_GUARD - 1);

  // byte_start is seen by the engine while the state already names the byte
  assign tx_byte = (state == spi_pkg::FRAME_BYTE1) ? byte1 : byte0;

  spi_byte_engine u_engine (
    .clk     (clk),
    .rst     (rst),
    .start   (byte_start),
    .tx_byte (tx_byte),
    .miso    (miso),
    .sclk    (sclk),
    .mosi    (mosi),
    .done    (byte_done),
    .rx_data (rx_data)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= spi_pkg::FRAME_IDLE;
      guard_cnt  <= '0;
      cs_n       <= 1'b1;
      byte_start <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      byte_start <= 1'b0;
      frame_done <= 1'b0;
      case (state)
        spi_pkg::FRAME_IDLE: begin
          guard_cnt <= '0;
          if (frame_start) begin
            cs_n  <= 1'b0;
            state <= spi_pkg::FRAME_SETUP;
          end
        end
        spi_pkg::FRAME_SETUP: begin
          guard_cnt <= guard_cnt + 1'b1;
          if (guard_end) begin
            byte_start <= 1'b1;
            state      <= spi_pkg::FRAME_BYTE0;
          end
        end
        spi_pkg::FRAME_BYTE0: begin
          if (byte_done) begin
            byte_start <= 1'b1;
            state      <= spi_pkg::FRAME_BYTE1;
          end
        end
        spi_pkg::FRAME_BYTE1: begin
          guard_cnt <= '0;
          if (byte_done) begin
            state <= spi_pkg::FRAME_HOLD;
          end
        end
        spi_pkg::FRAME_HOLD: begin
          guard_cnt <= guard_cnt + 1'b1;
          if (guard_end) begin
            cs_n       <= 1'b1;
            frame_done <= 1'b1;
            state      <= spi_pkg::FRAME_IDLE;
          end
        end
        default: state <= spi_pkg::FRAME_IDLE;
      endcase
    end
  end

  // Second byte carries the register contents on a read
  always_ff @(posedge clk) begin
    if (state == spi_pkg::FRAME_BYTE1 && byte_done) begin
      rx_byte <= rx_data;
    end
  end

endmodule

//--- verilog/spi_handshake_result.sv
`timescale 1ns/1ps

module spi_handshake_result (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  logic               frame_done,
  input  logic               reject,
  input  logic               write_cmd,
  input  spi_pkg::spi_byte_t rx_byte,
  output logic               accept,
  output logic               ack,
  output spi_pkg::spi_byte_t rdata,
  output logic               err
);

  spi_pkg::hs_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= spi_pkg::HS_IDLE;
      accept <= 1'b0;
      ack    <= 1'b0;
      err    <= 1'b0;
      rdata  <= '0;
    end else begin
      accept <= 1'b0;
      case (state)
        spi_pkg::HS_IDLE: begin
          if (req) begin
            accept <= 1'b1;
            state  <= spi_pkg::HS_BUSY;
          end
        end
        spi_pkg::HS_BUSY: begin
          if (frame_done || reject) begin
            ack <= 1'b1;
            err <= reject;
            // Writes and rejected commands return zero
            rdata <= (frame_done && !write_cmd) ? rx_byte : '0;
            state <= spi_pkg::HS_ACK;
          end
        end
        spi_pkg::HS_ACK: begin
          // Host may hold req as long as it likes
          if (!req) begin
            ack   <= 1'b0;
            state <= spi_pkg::HS_RELEASE;
          end
        end
        spi_pkg::HS_RELEASE: begin
          err   <= 1'b0;
          rdata <= '0;
          state <= spi_pkg::HS_IDLE;
        end
        default: state <= spi_pkg::HS_IDLE;
      endcase
    end
  end

endmodule

//--- verilog/spi_reg_bridge.sv
`timescale 1ns/1ps

module spi_reg_bridge (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  logic               write,
  input  spi_pkg::reg_addr_t addr,
  input  spi_pkg::spi_byte_t wdata,
  input  logic               miso,
  output logic               ack,
  output spi_pkg::spi_byte_t rdata,
  output logic               err,
  output logic               cs_n,
  output logic               sclk,
  output logic               mosi
);

  logic accept;
  logic frame_start;
  logic reject;
  logic write_cmd;
  logic frame_done;
  spi_pkg::spi_byte_t byte0;
  spi_pkg::spi_byte_t byte1;
  spi_pkg::spi_byte_t rx_byte;

  spi_cmd_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .accept      (accept),
    .write       (write),
    .addr        (addr),
    .wdata       (wdata),
    .frame_start (frame_start),
    .byte0       (byte0),
    .byte1       (byte1),
    .reject      (reject),
    .write_cmd   (write_cmd)
  );

  spi_frame_exec u_exec (
    .clk         (clk),
    .rst         (rst),
    .frame_start (frame_start),
    .byte0       (byte0),
    .byte1       (byte1),
    .miso        (miso),
    .cs_n        (cs_n),
    .sclk        (sclk),
    .mosi        (mosi),
    .frame_done  (frame_done),
    .rx_byte     (rx_byte)
  );

  spi_handshake_result u_result (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .frame_done (frame_done),
    .reject     (reject),
    .write_cmd  (write_cmd),
    .rx_byte    (rx_byte),
    .accept     (accept),
    .ack        (ack),
    .rdata      (rdata),
    .err        (err)
  );

endmodule

//--- test/spi_periph_model.sv
`timescale 1ns/1ps

module spi_periph_model (
  input  logic cs_n,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  // Register file, all zero at the start of the run
  spi_pkg::spi_byte_t regs [spi_pkg::REG_COUNT] = '{default: '0};
  spi_pkg::spi_byte_t rx_sr = '0;
  spi_pkg::spi_byte_t cmd = '0;
  spi_pkg::spi_byte_t out_sr = '0;
  // 16 sclk pulses per frame, so the count is back at zero when a frame ends
  logic [3:0] bit_cnt = '0;
  logic cmd_in_range;

  assign miso = out_sr[7];
  assign cmd_in_range = cmd[6:0] < 7'(spi_pkg::REG_COUNT);

  // Mode 0 receive side
  always @(posedge sclk) begin
    if (!cs_n) begin
      rx_sr   <= {rx_sr[6:0], mosi};
      bit_cnt <= bit_cnt + 4'd1;
      // Command byte is the write bit over the address
      if (bit_cnt == 4'd7) begin
        cmd <= {rx_sr[6:0], mosi};
      end
      if (bit_cnt == 4'd15 && cmd[7] && cmd_in_range) begin
        regs[cmd[3:0]] <= {rx_sr[6:0], mosi};
      end
    end
  end

  // Transmit side, a new bit after every falling edge
  always @(negedge cs_n or negedge sclk) begin
    if (bit_cnt == 4'd8) begin
      out_sr <= cmd_in_range ? regs[cmd[3:0]] : 8'h00;
    end else if (bit_cnt == 4'd0) begin
      // Dummy byte while the command comes in
      out_sr <= '0;
    end else begin
      out_sr <= {out_sr[6:0], 1'b0};
    end
  end

endmodule

//--- test/tb_spi_reg_bridge.sv
`timescale 1ns/1ps

module tb_spi_reg_bridge;

  localparam int NUM_DIRECTED = 4;
  localparam int NUM_RANDOM = 200;
  // A command needs well under 100 cycles, doubled for margin
  localparam int CYCLE_LIMIT = (NUM_DIRECTED + NUM_RANDOM) * 100 * 2;
  localparam int ACK_WAIT_LIMIT = 200;
  localparam int ADDR_SPAN = 20;

  logic clk = 1'b0;
  logic rst;
  logic req;
  logic write;
  spi_pkg::reg_addr_t addr;
  spi_pkg::spi_byte_t wdata;
  logic miso;
  logic ack;
  spi_pkg::spi_byte_t rdata;
  logic err;
  logic cs_n;
  logic sclk;
  logic mosi;

  // Expected peripheral contents
  spi_pkg::spi_byte_t ref_regs [spi_pkg::REG_COUNT];
  int cycles = 0;
  int cs_falls = 0;

  always #50 clk = ~clk;

  spi_reg_bridge uut (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .write (write),
    .addr  (addr),
    .wdata (wdata),
    .miso  (miso),
    .ack   (ack),
    .rdata (rdata),
    .err   (err),
    .cs_n  (cs_n),
    .sclk  (sclk),
    .mosi  (mosi)
  );

  spi_periph_model u_periph (
    .cs_n (cs_n),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  always @(negedge cs_n) cs_falls <= cs_falls + 1;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  task automatic check_byte(input string name, input spi_pkg::spi_byte_t exp,
                            input spi_pkg::spi_byte_t act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "byte mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic report_stall(input string what);
    $display("Handshake stalled at %0t: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "handshake stall");
  endtask

  // Outputs are settled here and inputs change here
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic check_idle_pins();
    check_bit("cs_n", 1'b1, cs_n);
    check_bit("sclk", 1'b0, sclk);
  endtask

  task automatic run_command(input logic wr, input int a, input spi_pkg::spi_byte_t wd);
    logic in_range;
    spi_pkg::spi_byte_t exp_rdata;
    int falls_before;
    int waited;
    int delay;
    in_range = a < spi_pkg::REG_COUNT;
    exp_rdata = 8'h00;
    if (in_range && !wr) begin
      exp_rdata = ref_regs[a];
    end
    falls_before = cs_falls;
    write = wr;
    addr = spi_pkg::reg_addr_t'(a);
    wdata = wd;
    req = 1'b1;
    waited = 0;
    while (!ack) begin
      next_cycle();
      waited++;
      if (waited > ACK_WAIT_LIMIT) begin
        report_stall("ack never rose after req");
      end
    end
    check_bit("err", !in_range, err);
    check_byte("rdata", exp_rdata, rdata);
    if (!in_range) begin
      // Rejected command must leave the SPI pins alone
      check_bit("cs_n_activity", 1'b0, cs_falls != falls_before);
    end
    if (in_range && wr) begin
      ref_regs[a] = wd;
    end
    // Held req keeps ack high and no new frame may start
    delay = $urandom_range(0, 3);
    repeat (delay) begin
      next_cycle();
      check_bit("ack", 1'b1, ack);
      check_bit("cs_n", 1'b1, cs_n);
    end
    req = 1'b0;
    waited = 0;
    while (ack) begin
      next_cycle();
      waited++;
      if (waited > ACK_WAIT_LIMIT) begin
        report_stall("ack stayed high after req dropped");
      end
    end
    check_idle_pins();
    delay = $urandom_range(0, 3);
    repeat (delay) begin
      next_cycle();
      check_bit("ack", 1'b0, ack);
      check_idle_pins();
    end
  endtask

  initial begin
    void'($urandom(32'h15b6_f551));
    rst = 1'b1;
    req = 1'b0;
    write = 1'b0;
    addr = '0;
    wdata = '0;
    for (int i = 0; i < spi_pkg::REG_COUNT; i++) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;
    next_cycle();
    check_bit("ack", 1'b0, ack);
    check_bit("err", 1'b0, err);
    check_bit("cs_n", 1'b1, cs_n);
    check_bit("sclk", 1'b0, sclk);
    check_bit("mosi", 1'b0, mosi);

    // Write then read back, an untouched register, one reject
    run_command(1'b1, 5, 8'ha5);
    run_command(1'b0, 5, 8'h00);
    run_command(1'b0, 9, 8'h00);
    run_command(1'b1, 16, 8'h3c);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      run_command(1'($urandom_range(0, 1)), $urandom_range(0, ADDR_SPAN - 1),
                  spi_pkg::spi_byte_t'($urandom_range(0, 255)));
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- compile.f
verilog/spi_pkg.sv
verilog/spi_cmd_decode.sv
verilog/spi_byte_engine.sv
verilog/spi_frame_exec.sv
verilog/spi_handshake_result.sv
verilog/spi_reg_bridge.sv
test/spi_periph_model.sv
test/tb_spi_reg_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI register bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_spi_reg_bridge \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
